//--- Bender.yml
package:
  name: adc_capture

sources:
  - files:
      - logic/adc_capture_pkg.sv
      - logic/sample_fifo.sv
      - logic/capture_control.sv
      - logic/sample_packer.sv
      - logic/byte_reader.sv
      - logic/adc_capture_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/adc_capture_tb.sv

//--- adc_capture.f
+incdir+tests
logic/adc_capture_pkg.sv
logic/sample_fifo.sv
logic/capture_control.sv
logic/sample_packer.sv
logic/byte_reader.sv
logic/adc_capture_top.sv
tests/adc_capture_tb.sv

//--- logic/adc_capture_pkg.sv
`default_nettype none

package adc_capture_pkg;

    localparam int SAMPLE_W         = 12;
    localparam int WORD_W           = 36;
    localparam int SAMPLES_PER_WORD = 3;

    // configuration input widths
    localparam int PRESAMPLE_W   = 10;
    localparam int MAX_SAMPLES_W = 16;
    localparam int DOWNSAMPLE_W  = 13;

    typedef enum logic [2:0] {
        st_idle,
        st_presamp_filling,   // collecting the presample window
        st_presamp_full,      // window full, drain one per write
        st_triggered,
        st_done
    } capture_state_e;

    // bit positions in the error status register
    typedef enum int {
        err_word_underflow   = 0,
        err_word_overflow    = 1,
        err_sample_underflow = 2,
        err_sample_overflow  = 3,
        err_presamp          = 4,
        err_clip             = 5,
        err_downsample       = 6
    } error_bit_e;

endpackage

`default_nettype wire

//--- logic/adc_capture_top.sv
`default_nettype none

module adc_capture_top #(
    parameter int SAMPLE_DEPTH = 512,
    parameter int WORD_DEPTH   = 64
) (
    input  wire                                      adc_sampleclk,
    input  wire                                      reset,
    input  wire [adc_capture_pkg::SAMPLE_W-1:0]      adc_datain_i,
    input  wire                                      arm_i,
    input  wire                                      adc_capture_go_i,
    input  wire [adc_capture_pkg::PRESAMPLE_W-1:0]   presample_i,
    input  wire [adc_capture_pkg::MAX_SAMPLES_W-1:0] max_samples_i,
    input  wire [adc_capture_pkg::DOWNSAMPLE_W-1:0]  downsample_i,
    input  wire                                      no_clip_errors_i,
    input  wire                                      low_res_i,
    input  wire                                      low_res_lsb_i,
    input  wire                                      fifo_read_fifoen_i,
    input  wire                                      clear_fifo_errors_i,
    output logic                                     adc_capture_stop_o,
    output logic                                     fifo_read_fifoempty_o,
    output logic [7:0]                               fifo_read_data_o,
    output logic                                     error_flag_o,
    output logic [6:0]                               error_stat_o
);

    logic                                 sample_wr, drain_pop, pack_pop, pack_en;
    logic [adc_capture_pkg::SAMPLE_W-1:0] sample_head;
    logic                                 sample_empty, sample_ovf, sample_unf;
    logic                                 word_wr, word_pop, word_full, word_empty;
    logic [adc_capture_pkg::WORD_W-1:0]   word_in, word_head;
    logic                                 word_ovf, word_unf;
    logic                                 presamp_err, clip_err, downsample_err;
    logic                                 arm_r;
    logic [6:0]                           err_set;

    capture_control u_control (
        .adc_sampleclk, .reset, .arm_i, .adc_capture_go_i, .adc_datain_i,
        .presample_i, .max_samples_i, .downsample_i, .no_clip_errors_i,
        .sample_empty_i(sample_empty), .sample_wr_o(sample_wr), .drain_pop_o(drain_pop),
        .pack_en_o(pack_en), .adc_capture_stop_o, .presamp_err_o(presamp_err),
        .clip_err_o(clip_err), .downsample_err_o(downsample_err)
    );

    sample_fifo #(.WIDTH(adc_capture_pkg::SAMPLE_W), .DEPTH(SAMPLE_DEPTH)) u_sample_fifo (
        .adc_sampleclk, .reset, .wr_en_i(sample_wr), .din_i(adc_datain_i),
        .rd_en_i(drain_pop || pack_pop), .dout_o(sample_head), .full_o(),
        .empty_o(sample_empty), .overflow_o(sample_ovf), .underflow_o(sample_unf)
    );

    sample_packer u_packer (
        .adc_sampleclk, .reset, .pack_en_i(pack_en), .sample_i(sample_head),
        .sample_empty_i(sample_empty), .word_full_i(word_full),
        .sample_pop_o(pack_pop), .word_wr_o(word_wr), .word_o(word_in)
    );

    sample_fifo #(.WIDTH(adc_capture_pkg::WORD_W), .DEPTH(WORD_DEPTH)) u_word_fifo (
        .adc_sampleclk, .reset, .wr_en_i(word_wr), .din_i(word_in),
        .rd_en_i(word_pop), .dout_o(word_head), .full_o(word_full),
        .empty_o(word_empty), .overflow_o(word_ovf), .underflow_o(word_unf)
    );

    byte_reader u_reader (
        .adc_sampleclk, .reset, .fifo_read_fifoen_i, .low_res_i, .low_res_lsb_i,
        .word_i(word_head), .word_empty_i(word_empty), .word_pop_o(word_pop),
        .fifo_read_data_o
    );

    assign fifo_read_fifoempty_o = word_empty;
    assign error_flag_o          = |error_stat_o;

    always_comb begin
        err_set = '0;
        err_set[adc_capture_pkg::err_word_underflow]   = word_unf;
        err_set[adc_capture_pkg::err_word_overflow]    = word_ovf;
        err_set[adc_capture_pkg::err_sample_underflow] = sample_unf;
        err_set[adc_capture_pkg::err_sample_overflow]  = sample_ovf;
        err_set[adc_capture_pkg::err_presamp]          = presamp_err;
        err_set[adc_capture_pkg::err_clip]             = clip_err;
        err_set[adc_capture_pkg::err_downsample]       = downsample_err;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r        <= 1'b0;
            error_stat_o <= '0;
        end else begin
            arm_r <= arm_i;
            if (clear_fifo_errors_i || (arm_i && !arm_r))
                error_stat_o <= err_set;   // new pulses survive the clear
            else
                error_stat_o <= error_stat_o | err_set;
        end
    end

endmodule

`default_nettype wire

//--- logic/byte_reader.sv
`default_nettype none

module byte_reader (
    input  wire                                 adc_sampleclk,
    input  wire                                 reset,
    input  wire                                 fifo_read_fifoen_i,
    input  wire                                 low_res_i,
    input  wire                                 low_res_lsb_i,
    input  wire [adc_capture_pkg::WORD_W-1:0]   word_i,
    input  wire                                 word_empty_i,
    output logic                                word_pop_o,
    output logic [7:0]                          fifo_read_data_o
);

    logic [3:0]                           byte_idx;
    logic [3:0]                           nibble;    // low bits of the first hi-res word
    logic [adc_capture_pkg::SAMPLE_W-1:0] lr_sample;
    logic                                 last_byte;
    logic                                 wrap;
    logic                                 advance;

    assign last_byte = low_res_i ? (byte_idx == 4'd2) : (byte_idx == 4'd3 || byte_idx == 4'd8);
    assign wrap      = low_res_i ? (byte_idx == 4'd2) : (byte_idx == 4'd8);
    assign advance   = fifo_read_fifoen_i && !word_empty_i;
    // an empty read still pops so the FIFO flags the underflow
    assign word_pop_o = fifo_read_fifoen_i && (last_byte || word_empty_i);

    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            byte_idx <= '0;
        else if (advance)
            byte_idx <= wrap ? 4'd0 : byte_idx + 1'b1;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (advance && !low_res_i && (byte_idx == 4'd3))
            nibble <= word_i[3:0];
    end

    always_comb begin
        case (byte_idx[1:0])
            2'd0:    lr_sample = word_i[35:24];
            2'd1:    lr_sample = word_i[23:12];
            default: lr_sample = word_i[11:0];
        endcase

        if (low_res_i) begin
            fifo_read_data_o = low_res_lsb_i ? lr_sample[7:0] : lr_sample[11:4];
        end else begin
            case (byte_idx)   // 72-bit stream over two words, msb first
                4'd0:    fifo_read_data_o = word_i[35:28];
                4'd1:    fifo_read_data_o = word_i[27:20];
                4'd2:    fifo_read_data_o = word_i[19:12];
                4'd3:    fifo_read_data_o = word_i[11:4];
                4'd4:    fifo_read_data_o = {nibble, word_i[35:32]};
                4'd5:    fifo_read_data_o = word_i[31:24];
                4'd6:    fifo_read_data_o = word_i[23:16];
                4'd7:    fifo_read_data_o = word_i[15:8];
                default: fifo_read_data_o = word_i[7:0];
            endcase
        end
    end

    a_idx_in_range: assert property (@(posedge adc_sampleclk) disable iff (reset)
        byte_idx <= (low_res_i ? 4'd2 : 4'd8));

endmodule

`default_nettype wire

//--- logic/capture_control.sv
`default_nettype none

module capture_control (
    input  wire                                      adc_sampleclk,
    input  wire                                      reset,
    input  wire                                      arm_i,
    input  wire                                      adc_capture_go_i,
    input  wire [adc_capture_pkg::SAMPLE_W-1:0]      adc_datain_i,
    input  wire [adc_capture_pkg::PRESAMPLE_W-1:0]   presample_i,
    input  wire [adc_capture_pkg::MAX_SAMPLES_W-1:0] max_samples_i,
    input  wire [adc_capture_pkg::DOWNSAMPLE_W-1:0]  downsample_i,
    input  wire                                      no_clip_errors_i,
    input  wire                                      sample_empty_i,
    output logic                                     sample_wr_o,
    output logic                                     drain_pop_o,
    output logic                                     pack_en_o,
    output logic                                     adc_capture_stop_o,
    output logic                                     presamp_err_o,
    output logic                                     clip_err_o,
    output logic                                     downsample_err_o
);

    localparam int CNT_W = adc_capture_pkg::MAX_SAMPLES_W + 1;

    adc_capture_pkg::capture_state_e          state;
    logic                                     arm_r;
    logic                                     armed;
    logic [adc_capture_pkg::DOWNSAMPLE_W-1:0] ds_cnt;
    logic [adc_capture_pkg::PRESAMPLE_W-1:0]  pre_cnt;
    logic [CNT_W-1:0]                         stored_cnt;
    logic [CNT_W-1:0]                         stored_next;
    logic [CNT_W-1:0]                         target;
    logic [1:0]                               target_pad;
    logic                                     arm_go;
    logic                                     keep;
    logic                                     trig;
    logic                                     presampling;
    logic                                     wr_state;

    assign arm_go      = arm_i && !arm_r && (state == adc_capture_pkg::st_idle);
    assign keep        = (ds_cnt == '0);   // downsampler keep pulse
    assign presampling = (state == adc_capture_pkg::st_presamp_filling) ||
                         (state == adc_capture_pkg::st_presamp_full);
    assign trig        = adc_capture_go_i &&
                         (presampling || (state == adc_capture_pkg::st_idle && armed));
    assign wr_state    = presampling || trig || (state == adc_capture_pkg::st_triggered);
    assign sample_wr_o = keep && wr_state;
    assign drain_pop_o = sample_wr_o && !trig && (state == adc_capture_pkg::st_presamp_full);
    assign pack_en_o   = (state == adc_capture_pkg::st_triggered) ||
                         (state == adc_capture_pkg::st_done);

    // pad to the next multiple of three
    assign target_pad  = 2'((3 - max_samples_i % 3) % 3);

    // presamples count as stored once the trigger is seen
    assign stored_next = ((state == adc_capture_pkg::st_triggered) ? stored_cnt : CNT_W'(pre_cnt))
                         + CNT_W'(sample_wr_o);

    assign presamp_err_o    = adc_capture_go_i && (state == adc_capture_pkg::st_presamp_filling);
    assign clip_err_o       = sample_wr_o && !no_clip_errors_i &&
                              ((adc_datain_i == '0) || (adc_datain_i == '1));
    assign downsample_err_o = arm_go && (downsample_i != '0) && (presample_i != '0);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state              <= adc_capture_pkg::st_idle;
            arm_r              <= 1'b0;
            armed              <= 1'b0;
            ds_cnt             <= '0;
            pre_cnt            <= '0;
            stored_cnt         <= '0;
            target             <= '0;
            adc_capture_stop_o <= 1'b0;
        end else begin
            arm_r <= arm_i;
            if (arm_go || (ds_cnt == downsample_i))
                ds_cnt <= '0;
            else
                ds_cnt <= ds_cnt + 1'b1;

            case (state)
                adc_capture_pkg::st_idle: begin
                    if (arm_go) begin
                        adc_capture_stop_o <= 1'b0;
                        pre_cnt            <= '0;
                        stored_cnt         <= '0;
                        target             <= CNT_W'(max_samples_i) + CNT_W'(target_pad);
                        armed              <= (presample_i == '0);
                        if (presample_i != '0)
                            state <= adc_capture_pkg::st_presamp_filling;
                    end else if (trig) begin
                        state <= adc_capture_pkg::st_triggered;
                    end
                end
                adc_capture_pkg::st_presamp_filling: begin
                    if (trig) begin
                        state <= adc_capture_pkg::st_triggered;  // early trigger, keep going
                    end else if (sample_wr_o) begin
                        pre_cnt <= pre_cnt + 1'b1;
                        if (pre_cnt + 1'b1 == presample_i)
                            state <= adc_capture_pkg::st_presamp_full;
                    end
                end
                adc_capture_pkg::st_presamp_full: begin
                    if (trig)
                        state <= adc_capture_pkg::st_triggered;
                end
                adc_capture_pkg::st_done: begin
                    if (sample_empty_i)
                        state <= adc_capture_pkg::st_idle;  // packer has drained everything
                end
                default: ;
            endcase

            if (trig)
                armed <= 1'b0;
            if (trig || (state == adc_capture_pkg::st_triggered && sample_wr_o)) begin
                stored_cnt <= stored_next;
                if (sample_wr_o && (stored_next >= target)) begin
                    state              <= adc_capture_pkg::st_done;
                    adc_capture_stop_o <= 1'b1;
                end
            end
        end
    end

    // a drain never runs the presample window dry
    a_drain_not_empty: assert property (@(posedge adc_sampleclk) disable iff (reset)
        drain_pop_o |-> !sample_empty_i);

endmodule

`default_nettype wire

//--- logic/sample_fifo.sv
`default_nettype none

module sample_fifo #(
    parameter int WIDTH = 12,
    parameter int DEPTH = 512
) (
    input  wire              adc_sampleclk,
    input  wire              reset,
    input  wire              wr_en_i,
    input  wire [WIDTH-1:0]  din_i,
    input  wire              rd_en_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             full_o,
    output logic             empty_o,
    output logic             overflow_o,
    output logic             underflow_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_wr;
    logic             do_rd;

    assign full_o  = (count == CW'(DEPTH));
    assign empty_o = (count == '0);
    assign do_rd   = rd_en_i && !empty_o;
    assign do_wr   = wr_en_i && (!full_o || do_rd); // a pop frees the slot this cycle
    assign dout_o  = mem[rd_ptr];                    // first word falls through

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr)
            mem[wr_ptr] <= din_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count       <= count + CW'(do_wr) - CW'(do_rd);
            overflow_o  <= wr_en_i && !do_wr;  // lost write
            underflow_o <= rd_en_i && empty_o;
        end
    end

    a_count_in_range: assert property (@(posedge adc_sampleclk) disable iff (reset)
        count <= CW'(DEPTH));

endmodule

`default_nettype wire

//--- logic/sample_packer.sv
`default_nettype none

module sample_packer (
    input  wire                                 adc_sampleclk,
    input  wire                                 reset,
    input  wire                                 pack_en_i,
    input  wire [adc_capture_pkg::SAMPLE_W-1:0] sample_i,
    input  wire                                 sample_empty_i,
    input  wire                                 word_full_i,
    output logic                                sample_pop_o,
    output logic                                word_wr_o,
    output logic [adc_capture_pkg::WORD_W-1:0]  word_o
);

    localparam int SHIFT_W =
        adc_capture_pkg::SAMPLE_W * (adc_capture_pkg::SAMPLES_PER_WORD - 1);
    localparam logic [1:0] LAST_PHASE = 2'(adc_capture_pkg::SAMPLES_PER_WORD - 1);

    logic [1:0]         phase;
    logic [SHIFT_W-1:0] shift;

    // full word FIFO stalls the packer
    assign sample_pop_o = pack_en_i && !sample_empty_i && !word_full_i;
    assign word_wr_o    = sample_pop_o && (phase == LAST_PHASE);
    assign word_o       = {shift, sample_i};   // oldest sample on top

    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            phase <= '0;
        else if (sample_pop_o)
            phase <= (phase == LAST_PHASE) ? 2'd0 : phase + 1'b1;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (sample_pop_o && (phase != LAST_PHASE))
            shift <= {shift[adc_capture_pkg::SAMPLE_W-1:0], sample_i};
    end

    // each capture packs from a word boundary
    a_start_on_word: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(pack_en_i) |-> (phase == '0));

endmodule

`default_nettype wire

//--- tests/capture_cases.svh
`ifndef CAPTURE_CASES_SVH
`define CAPTURE_CASES_SVH

typedef struct packed {
    logic [9:0]  presample;
    logic [15:0] max_samples;
    logic [12:0] downsample;
    logic        low_res;
    logic        low_res_lsb;
    logic        no_clip;
    logic [11:0] ramp_start;
    logic [15:0] trig_delay;   // cycles from the arm edge to the trigger edge
    logic [6:0]  exp_err;
    logic [15:0] exp_bytes;
} capture_case_t;

localparam int NUM_CASES = 10;

capture_case_t cases [NUM_CASES];

task automatic set_case(input int idx, input int unsigned p, input int unsigned m,
                        input int unsigned d, input bit lr, input bit lsb, input bit nc,
                        input int unsigned start, input int unsigned delay,
                        input int unsigned err, input int unsigned nbytes);
    cases[idx] = {10'(p), 16'(m), 13'(d), lr, lsb, nc, 12'(start), 16'(delay),
                  7'(err), 16'(nbytes)};
endtask

// columns: presample, max samples, downsample, low_res, low_res_lsb, no_clip,
// ramp start, trigger delay, expected error_stat, expected byte count
task automatic load_cases();
    set_case(0, 0, 24, 0, 0, 0, 0, 12'h100, 5, 7'h00, 36);
    set_case(1, 0, 22, 0, 1, 0, 0, 12'h234, 3, 7'h00, 24);   // target rounds up to 24
    set_case(2, 0, 30, 0, 1, 1, 0, 12'h3f0, 7, 7'h00, 30);
    set_case(3, 6, 36, 0, 0, 0, 0, 12'h500, 12, 7'h00, 54);  // full presample window
    set_case(4, 8, 33, 0, 1, 0, 0, 12'h600, 4, 7'h10, 33);   // early trigger
    set_case(5, 0, 24, 2, 0, 0, 0, 12'h080, 6, 7'h00, 36);
    set_case(6, 4, 24, 2, 0, 0, 0, 12'h700, 20, 7'h40, 36);
    set_case(7, 0, 18, 0, 1, 1, 0, 12'hff8, 2, 7'h20, 18);   // ramp wraps through 0xfff
    set_case(8, 0, 18, 0, 0, 0, 1, 12'hff0, 3, 7'h00, 27);
    set_case(9, 0, 720, 0, 0, 0, 0, 12'h100, 4, 7'h08, 1053); // 702 of 704 kept samples
endtask

`endif

//--- tests/adc_capture_tb.sv
`default_nettype none

module adc_capture_tb;

    logic        adc_sampleclk;
    logic        reset;
    logic [11:0] adc_datain_i;
    logic        arm_i;
    logic        adc_capture_go_i;
    logic [9:0]  presample_i;
    logic [15:0] max_samples_i;
    logic [12:0] downsample_i;
    logic        no_clip_errors_i;
    logic        low_res_i;
    logic        low_res_lsb_i;
    logic        fifo_read_fifoen_i;
    logic        clear_fifo_errors_i;
    logic        adc_capture_stop_o;
    logic        fifo_read_fifoempty_o;
    logic [7:0]  fifo_read_data_o;
    logic        error_flag_o;
    logic [6:0]  error_stat_o;

    int unsigned value_errs = 0;
    int unsigned other_errs = 0;
    int unsigned cycle_cnt = 0;
    int unsigned cycle_limit = 0;
    logic [31:0] lfsr;
    logic [7:0]  rd_bytes [$];

    `include "capture_cases.svh"

    adc_capture_top dut_i (
        .adc_sampleclk(adc_sampleclk), .reset(reset), .adc_datain_i(adc_datain_i),
        .arm_i(arm_i), .adc_capture_go_i(adc_capture_go_i), .presample_i(presample_i),
        .max_samples_i(max_samples_i), .downsample_i(downsample_i),
        .no_clip_errors_i(no_clip_errors_i), .low_res_i(low_res_i),
        .low_res_lsb_i(low_res_lsb_i), .fifo_read_fifoen_i(fifo_read_fifoen_i),
        .clear_fifo_errors_i(clear_fifo_errors_i), .adc_capture_stop_o(adc_capture_stop_o),
        .fifo_read_fifoempty_o(fifo_read_fifoempty_o), .fifo_read_data_o(fifo_read_data_o),
        .error_flag_o(error_flag_o), .error_stat_o(error_stat_o)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #4 adc_sampleclk = ~adc_sampleclk;
    end

    always @(posedge adc_sampleclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: DUT still busy after %0d cycles", cycle_limit);
            $display("value errors %0d, other errors %0d", value_errs, other_errs);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] shift_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int unsigned timeout_cycles();
        int unsigned total;
        total = 0;
        for (int i = 0; i < NUM_CASES; i++)
            total = total + cases[i].trig_delay + 4 * cases[i].max_samples + 200;
        return total;
    endfunction

    // oldest sample kept in the FIFO, from the keep pattern and the presample window
    function automatic int unsigned expected_first_sample(input capture_case_t c);
        int unsigned per;
        int unsigned n_before;
        int unsigned pre;
        per      = c.downsample + 1;
        n_before = (c.trig_delay - 1 + per - 1) / per;   // kept edges before the trigger
        pre      = (c.presample < n_before) ? c.presample : n_before;
        return c.ramp_start + 1 + (n_before - pre) * per;
    endfunction

    task automatic check_value(input string name, input int unsigned got,
                               input int unsigned exp);
        assert (got == exp) else begin
            value_errs++;
            $display("ERROR %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge adc_sampleclk);
        #1;
        adc_datain_i = adc_datain_i + 1'b1;   // ramp steps every cycle
    endtask

    task automatic read_bytes();
        rd_bytes.delete();
        while (!fifo_read_fifoempty_o) begin
            rd_bytes.push_back(fifo_read_data_o);
            fifo_read_fifoen_i = 1'b1;
            next_cycle();
            fifo_read_fifoen_i = 1'b0;
            lfsr = shift_lfsr(lfsr);
            if (lfsr[0])
                next_cycle();   // idle gap between strobes
        end
    endtask

    task automatic check_samples(input capture_case_t c);
        int unsigned per;
        int unsigned first;
        int unsigned acc;
        int unsigned nbits;
        int unsigned n;
        logic [11:0] exp_s;
        logic [11:0] got_s;
        logic [7:0]  exp_b;
        per   = c.downsample + 1;
        first = expected_first_sample(c);
        acc   = 0;
        nbits = 0;
        n     = 0;
        foreach (rd_bytes[i]) begin
            if (c.low_res) begin
                exp_s = 12'(first + i * per);
                exp_b = c.low_res_lsb ? exp_s[7:0] : exp_s[11:4];
                check_value($sformatf("fifo_read_data_o byte %0d", i), rd_bytes[i], exp_b);
            end else begin
                acc   = (acc << 8) | rd_bytes[i];   // msb first stream
                nbits = nbits + 8;
                if (nbits >= 12) begin
                    nbits = nbits - 12;
                    got_s = 12'(acc >> nbits);
                    acc   = acc & ((1 << nbits) - 1);
                    exp_s = 12'(first + n * per);
                    check_value($sformatf("fifo_read_data_o sample %0d", n), got_s, exp_s);
                    n++;
                end
            end
        end
        assert (nbits == 0) else begin
            other_errs++;
            $display("hi-res byte stream ended partway through a sample");
        end
    endtask

    task automatic check_errors(input capture_case_t c);
        logic [6:0] with_unf;
        with_unf = c.exp_err;
        with_unf[adc_capture_pkg::err_word_underflow] = 1'b1;
        check_value("error_stat_o", error_stat_o, c.exp_err);
        check_value("error_flag_o", error_flag_o, c.exp_err != 0);
        fifo_read_fifoen_i = 1'b1;   // strobe on an empty word FIFO
        next_cycle();
        fifo_read_fifoen_i = 1'b0;
        next_cycle();
        check_value("error_stat_o", error_stat_o, with_unf);
        clear_fifo_errors_i = 1'b1;
        next_cycle();
        clear_fifo_errors_i = 1'b0;
        check_value("error_stat_o", error_stat_o, 0);
        check_value("error_flag_o", error_flag_o, 0);
    endtask

    task automatic run_case(input int idx);
        capture_case_t c;
        int unsigned   target;
        int unsigned   stop_wait;
        int unsigned   exp_wait;
        c        = cases[idx];
        target   = (c.max_samples + 2) / 3 * 3;
        // last stored sample sits target-1 kept steps after the first one
        exp_wait = expected_first_sample(c) + (target - 1) * (c.downsample + 1)
                   - c.ramp_start - c.trig_delay;
        $display("case %0d: presample %0d, max %0d, downsample %0d, low_res %0b",
                 idx, c.presample, c.max_samples, c.downsample, c.low_res);
        next_cycle();
        presample_i      = c.presample;
        max_samples_i    = c.max_samples;
        downsample_i     = c.downsample;
        low_res_i        = c.low_res;
        low_res_lsb_i    = c.low_res_lsb;
        no_clip_errors_i = c.no_clip;
        next_cycle();
        adc_datain_i = c.ramp_start;
        arm_i        = 1'b1;   // rising edge seen at the next clock
        next_cycle();
        arm_i = 1'b0;
        check_value("adc_capture_stop_o", adc_capture_stop_o, 0);   // cleared by the arm
        repeat (c.trig_delay - 1) next_cycle();
        adc_capture_go_i = 1'b1;
        next_cycle();
        adc_capture_go_i = 1'b0;
        stop_wait = 0;
        while (!adc_capture_stop_o) begin
            next_cycle();
            stop_wait++;
        end
        check_value("adc_capture_stop_o delay", stop_wait, exp_wait);
        read_bytes();
        check_value("byte count", rd_bytes.size(), c.exp_bytes);
        check_value("adc_capture_stop_o", adc_capture_stop_o, 1);   // held until the next arm
        check_samples(c);
        check_errors(c);
    endtask

    initial begin
        reset               = 1'b1;
        adc_datain_i        = '0;
        arm_i               = 1'b0;
        adc_capture_go_i    = 1'b0;
        presample_i         = '0;
        max_samples_i       = '0;
        downsample_i        = '0;
        no_clip_errors_i    = 1'b0;
        low_res_i           = 1'b0;
        low_res_lsb_i       = 1'b0;
        fifo_read_fifoen_i  = 1'b0;
        clear_fifo_errors_i = 1'b0;
        lfsr                = 32'hee72;
        load_cases();
        cycle_limit = timeout_cycles();
        repeat (2) @(posedge adc_sampleclk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < NUM_CASES; i++)
            run_case(i);
        $display("value errors %0d, other errors %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
